// ==== logic/mipsPkg.sv ====
package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// instruction word views
	//////////////////////////////////////////////////////////////////////

	// supported opcodes
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opLb    = 6'h20,
		opLw    = 6'h23,
		opSb    = 6'h28,
		opSw    = 6'h2b
	} opT;

	// r-type function codes
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef struct packed {
		opT          op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		functT       funct;
	} rFmtT;

	typedef struct packed {
		opT          op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iFmtT;

	typedef struct packed {
		opT          op;
		logic [25:0] target;
	} jFmtT;

	// one word, three decodings
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		jFmtT jFmt;
	} instrT;

	//////////////////////////////////////////////////////////////////////
	// control and hazard traffic
	//////////////////////////////////////////////////////////////////////

	// aluAdd must stay zero so a cleared ctrl word is a bubble
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memWrite;
		logic  memByte;
		logic  aluSrc;
		logic  regDst;
		logic  branch;
		logic  branchNe;
		logic  jump;
		aluOpT aluOp;
	} ctrlT;

	// execute operand source
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdMem  = 2'd1,
		fwdWb   = 2'd2
	} fwdT;

	typedef struct packed {
		logic stallF;
		logic stallD;
		logic flushE;
		logic fwdAD;
		logic fwdBD;
		fwdT  fwdAE;
		fwdT  fwdBE;
		logic freeze;
	} hazardT;

	typedef struct packed {
		logic [4:0] rsD;
		logic [4:0] rtD;
		logic [4:0] rsE;
		logic [4:0] rtE;
		logic [4:0] writeRegE;
		logic [4:0] writeRegM;
		logic [4:0] writeRegW;
		logic       regWriteE;
		logic       regWriteM;
		logic       regWriteW;
		logic       memToRegE;
		logic       memToRegM;
		logic       branchD;
	} stageInfoT;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import mipsPkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  aluOpT       op,
	output logic [31:0] y
);

	logic [31:0] diff;
	logic        less;

	// shared subtract
	assign diff = a - b;

	// signed compare from the sign of the difference
	// corrected when the operands differ in sign
	assign less = (a[31] != b[31]) ? a[31] : diff[31];

	always_comb begin
		case (op)
			aluAdd:  y = a + b;
			aluSub:  y = diff;
			aluAnd:  y = a & b;
			aluOr:   y = a | b;
			aluSlt:  y = {31'd0, less};
			// unused encodings
			default: y = 32'd0;
		endcase
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	// r0 cleared at reset and never written after
	always_ff @(posedge clk) begin
		if (rst) begin
			regs[0] <= 32'd0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write shows up on the read port
	assign rd1 = (we && wa != 5'd0 && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa != 5'd0 && wa == ra2) ? wd : regs[ra2];

	// zero register survives the write port and the bypass
	assert property (@(posedge clk) disable iff (rst) (ra1 == 5'd0) |-> (rd1 == 32'd0));

endmodule

// ==== logic/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
	input  instrT instrD,
	output ctrlT  ctrlD
);

	// r-type funct recognized
	logic knownFunct;
	aluOpT rAluOp;

	// funct through the r view
	always_comb begin
		knownFunct = 1'b1;
		case (instrD.rFmt.funct)
			fnAdd:   rAluOp = aluAdd;
			fnSub:   rAluOp = aluSub;
			fnAnd:   rAluOp = aluAnd;
			fnOr:    rAluOp = aluOr;
			fnSlt:   rAluOp = aluSlt;
			default: begin
				rAluOp = aluAdd;
				knownFunct = 1'b0;
			end
		endcase
	end

	// opcode through the i view
	always_comb begin
		// start from a bubble
		ctrlD = '0;
		case (instrD.iFmt.op)
			opRtype: begin
				ctrlD.regWrite = knownFunct;
				ctrlD.regDst = 1'b1;
				ctrlD.aluOp = rAluOp;
			end
			opAddi: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
			end
			// loads, lb adds the byte flag
			opLw, opLb: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.memByte = (instrD.iFmt.op == opLb);
			end
			opSw, opSb: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.memByte = (instrD.iFmt.op == opSb);
			end
			// compare happens in decode
			opBeq: begin
				ctrlD.branch = 1'b1;
			end
			opBne: begin
				ctrlD.branch = 1'b1;
				ctrlD.branchNe = 1'b1;
			end
			opJ: begin
				ctrlD.jump = 1'b1;
			end
			default: begin
				ctrlD = '0;
			end
		endcase
	end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  stageInfoT stageInfo,
	input  logic      iStall,
	input  logic      dStall,
	output hazardT    hazard,
	output logic      longestStall
);

	logic lwStall;
	logic branchStall;
	logic stall;
	logic freeze;

	// memory result first as the younger one
	function automatic fwdT selFwd(input logic [4:0] src, input stageInfoT info);
		fwdT sel;
		sel = fwdNone;
		if (src != 5'd0 && info.regWriteM && info.writeRegM == src) begin
			sel = fwdMem;
		end else if (src != 5'd0 && info.regWriteW && info.writeRegW == src) begin
			sel = fwdWb;
		end
		return sel;
	endfunction

	// load in execute feeding decode
	assign lwStall = stageInfo.memToRegE && stageInfo.writeRegE != 5'd0 &&
		(stageInfo.writeRegE == stageInfo.rsD || stageInfo.writeRegE == stageInfo.rtD);

	// branch waits for an alu result in execute
	// or a load still in memory
	assign branchStall = stageInfo.branchD && (
		(stageInfo.regWriteE && stageInfo.writeRegE != 5'd0 &&
			(stageInfo.writeRegE == stageInfo.rsD || stageInfo.writeRegE == stageInfo.rtD)) ||
		(stageInfo.memToRegM && stageInfo.writeRegM != 5'd0 &&
			(stageInfo.writeRegM == stageInfo.rsD || stageInfo.writeRegM == stageInfo.rtD)));

	assign stall = lwStall | branchStall;
	// either memory stalling holds the whole pipe
	assign freeze = iStall | dStall;
	assign longestStall = freeze;

	always_comb begin
		hazard.stallF = stall;
		hazard.stallD = stall;
		hazard.flushE = stall;
		// decode compare only from memory stage
		hazard.fwdAD = stageInfo.rsD != 5'd0 && stageInfo.regWriteM &&
			stageInfo.writeRegM == stageInfo.rsD;
		hazard.fwdBD = stageInfo.rtD != 5'd0 && stageInfo.regWriteM &&
			stageInfo.writeRegM == stageInfo.rtD;
		hazard.fwdAE = selFwd(stageInfo.rsE, stageInfo);
		hazard.fwdBE = selFwd(stageInfo.rtE, stageInfo);
		hazard.freeze = freeze;
	end

	// a flush puts a bubble into execute
	assert property (@(posedge clk) disable iff (rst)
		hazard.flushE && !hazard.freeze |=> !stageInfo.regWriteE && !stageInfo.memToRegE);

	// a reported stall keeps every stage in place
	assert property (@(posedge clk) disable iff (rst) longestStall |=> $stable(stageInfo));

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps

module datapath import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	output instrT       instrD,
	input  ctrlT        ctrlD,
	input  hazardT      hazard,
	output stageInfoT   stageInfo,
	output logic        memWriteM,
	output logic [3:0]  byteEnM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input  logic [31:0] readDataM,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	// pipeline payloads, control travels beside them
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] srcA;
		logic [31:0] srcB;
		logic [31:0] signImm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
	} idExT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] storeData;
		logic [4:0]  writeReg;
	} exMemT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] readData;
		logic [4:0]  writeReg;
	} memWbT;

	logic [31:0] pcNextF, pcPlus4F;
	logic [31:0] pcD, pcPlus4D, signImmD, rd1D, rd2D, cmpAD, cmpBD;
	logic [31:0] branchTargetD, jumpTargetD;
	logic        takenD;
	ctrlT        ctrlE, ctrlM, ctrlW;
	idExT        idEx;
	exMemT       exMem;
	memWbT       memWb;
	logic [31:0] srcAE, srcBFwdE, srcBE, aluOutE;
	logic [4:0]  writeRegE;
	logic [7:0]  loadByteW;
	logic [31:0] resultW;

	//////////////////////////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////////////////////////

	assign pcPlus4F = pcF + 32'd4;
	// jump wins, then a taken branch, else fall through
	assign pcNextF = ctrlD.jump ? jumpTargetD : (takenD ? branchTargetD : pcPlus4F);

	always_ff @(posedge clk) begin
		if (rst) begin
			pcF <= resetPc;
		end else if (!hazard.freeze && !hazard.stallF) begin
			pcF <= pcNextF;
		end
	end

	// if/id, zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;
		end else if (!hazard.freeze && !hazard.stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!hazard.freeze && !hazard.stallD) begin
			pcD <= pcF;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	assign pcPlus4D = pcD + 32'd4;
	assign signImmD = {{16{instrD.iFmt.imm[15]}}, instrD.iFmt.imm};
	assign branchTargetD = pcPlus4D + {signImmD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD.jFmt.target, 2'b00};

	// writeback results arrive through the register file bypass
	regFile regFileInst (
		.clk (clk),
		.rst (rst),
		.we  (ctrlW.regWrite & ~hazard.freeze),
		.ra1 (instrD.rFmt.rs),
		.ra2 (instrD.rFmt.rt),
		.wa  (memWb.writeReg),
		.wd  (resultW),
		.rd1 (rd1D),
		.rd2 (rd2D)
	);

	// branch compare sees memory-stage alu results
	assign cmpAD = hazard.fwdAD ? aluOutM : rd1D;
	assign cmpBD = hazard.fwdBD ? aluOutM : rd2D;
	assign takenD = ctrlD.branch & ((cmpAD == cmpBD) ^ ctrlD.branchNe);

	// id/ex, flush leaves a bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlE <= '0;
		end else if (!hazard.freeze) begin
			ctrlE <= hazard.flushE ? '0 : ctrlD;
		end
	end

	always_ff @(posedge clk) begin
		if (!hazard.freeze) begin
			idEx.pc      <= pcD;
			idEx.srcA    <= rd1D;
			idEx.srcB    <= rd2D;
			idEx.signImm <= signImmD;
			idEx.rs      <= instrD.rFmt.rs;
			idEx.rt      <= instrD.rFmt.rt;
			idEx.rd      <= instrD.rFmt.rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (hazard.fwdAE)
			fwdMem:  srcAE = aluOutM;
			fwdWb:   srcAE = resultW;
			default: srcAE = idEx.srcA;
		endcase
		case (hazard.fwdBE)
			fwdMem:  srcBFwdE = aluOutM;
			fwdWb:   srcBFwdE = resultW;
			default: srcBFwdE = idEx.srcB;
		endcase
	end

	assign srcBE = ctrlE.aluSrc ? idEx.signImm : srcBFwdE;
	assign writeRegE = ctrlE.regDst ? idEx.rd : idEx.rt;

	alu aluInst (
		.a  (srcAE),
		.b  (srcBE),
		.op (ctrlE.aluOp),
		.y  (aluOutE)
	);

	// ex/mem
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlM <= '0;
		end else if (!hazard.freeze) begin
			ctrlM <= ctrlE;
		end
	end

	always_ff @(posedge clk) begin
		if (!hazard.freeze) begin
			exMem <= '{pc: idEx.pc, aluOut: aluOutE, storeData: srcBFwdE, writeReg: writeRegE};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory
	//////////////////////////////////////////////////////////////////////

	assign aluOutM = exMem.aluOut;
	assign memWriteM = ctrlM.memWrite;
	// byte store goes to every lane, enables pick one
	assign writeDataM = ctrlM.memByte ? {4{exMem.storeData[7:0]}} : exMem.storeData;
	assign byteEnM = !ctrlM.memWrite ? 4'b0000 :
		(ctrlM.memByte ? (4'b0001 << aluOutM[1:0]) : 4'b1111);

	// mem/wb
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlW <= '0;
		end else if (!hazard.freeze) begin
			ctrlW <= ctrlM;
		end
	end

	always_ff @(posedge clk) begin
		if (!hazard.freeze) begin
			memWb <= '{pc: exMem.pc, aluOut: exMem.aluOut, readData: readDataM,
				writeReg: exMem.writeReg};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////////////////////////

	// little-endian lane select for lb
	always_comb begin
		case (memWb.aluOut[1:0])
			2'd0:    loadByteW = memWb.readData[7:0];
			2'd1:    loadByteW = memWb.readData[15:8];
			2'd2:    loadByteW = memWb.readData[23:16];
			default: loadByteW = memWb.readData[31:24];
		endcase
	end

	assign resultW = !ctrlW.memToReg ? memWb.aluOut :
		(ctrlW.memByte ? {{24{loadByteW[7]}}, loadByteW} : memWb.readData);

	// trace only in cycles that really write
	assign debugWbPc = memWb.pc;
	assign debugWbRfWen = {4{ctrlW.regWrite & ~hazard.freeze}};
	assign debugWbRfWnum = memWb.writeReg;
	assign debugWbRfWdata = resultW;

	// hazard unit view of the pipe
	assign stageInfo = '{
		rsD: instrD.rFmt.rs, rtD: instrD.rFmt.rt, rsE: idEx.rs, rtE: idEx.rt,
		writeRegE: writeRegE, writeRegM: exMem.writeReg, writeRegW: memWb.writeReg,
		regWriteE: ctrlE.regWrite, regWriteM: ctrlM.regWrite, regWriteW: ctrlW.regWrite,
		memToRegE: ctrlE.memToReg, memToRegM: ctrlM.memToReg, branchD: ctrlD.branch
	};

	// a frozen core must not advance fetch
	assert property (@(posedge clk) disable iff (rst) hazard.freeze |=> $stable(pcF));

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	// instruction side
	output logic [31:0] pcF,
	input  logic [31:0] instrF,
	input  logic        iStall,
	// data side
	output logic        memWriteM,
	output logic [3:0]  byteEnM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	input  logic [31:0] readDataM,
	input  logic        dStall,
	// global hold
	output logic        longestStall,
	// writeback trace
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	// decode-stage instruction and its control word
	instrT     instrD;
	ctrlT      ctrlD;
	// hazard loop
	hazardT    hazard;
	stageInfoT stageInfo;

	controlDecoder decoderInst (
		.instrD (instrD),
		.ctrlD  (ctrlD)
	);

	hazardUnit hazardInst (
		.clk          (clk),
		.rst          (rst),
		.stageInfo    (stageInfo),
		.iStall       (iStall),
		.dStall       (dStall),
		.hazard       (hazard),
		.longestStall (longestStall)
	);

	datapath #(
		.resetPc (resetPc)
	) datapathInst (
		.clk            (clk),
		.rst            (rst),
		.pcF            (pcF),
		.instrF         (instrF),
		.instrD         (instrD),
		.ctrlD          (ctrlD),
		.hazard         (hazard),
		.stageInfo      (stageInfo),
		.memWriteM      (memWriteM),
		.byteEnM        (byteEnM),
		.aluOutM        (aluOutM),
		.writeDataM     (writeDataM),
		.readDataM      (readDataM),
		.debugWbPc      (debugWbPc),
		.debugWbRfWen   (debugWbRfWen),
		.debugWbRfWnum  (debugWbRfWnum),
		.debugWbRfWdata (debugWbRfWdata)
	);

endmodule

// ==== dv/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

	// word offsets inside the data file
	localparam int progBase = 'h00;
	localparam int dataBase = 'h40;
	localparam int finalBase = 'h48;
	localparam int countIdx = 'h50;
	localparam int traceBase = 'h60;
	// cycles allowed between two register writes
	localparam int wbTimeout = 200;
	localparam logic [31:0] resetPc = 32'h0000_0000;

	logic        clk;
	logic        rst;
	logic        rstReq;
	logic [31:0] instrF;
	logic [31:0] readDataM;
	logic        iStall;
	logic        dStall;
	logic [31:0] pcF;
	logic        memWriteM;
	logic [3:0]  byteEnM;
	logic [31:0] aluOutM;
	logic [31:0] writeDataM;
	logic        longestStall;
	logic [31:0] debugWbPc;
	logic [3:0]  debugWbRfWen;
	logic [4:0]  debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	// program, data images and expected trace
	logic [31:0] inputWords [256];
	// eight words of data memory
	logic [31:0] dataMem [8];
	integer      seed;
	logic        stallsOn;
	int          traceLen;

	mipsCore mipsCore_inst (
		.clk            (clk),
		.rst            (rst),
		.pcF            (pcF),
		.instrF         (instrF),
		.iStall         (iStall),
		.memWriteM      (memWriteM),
		.byteEnM        (byteEnM),
		.aluOutM        (aluOutM),
		.writeDataM     (writeDataM),
		.readDataM      (readDataM),
		.dStall         (dStall),
		.longestStall   (longestStall),
		.debugWbPc      (debugWbPc),
		.debugWbRfWen   (debugWbRfWen),
		.debugWbRfWnum  (debugWbRfWnum),
		.debugWbRfWdata (debugWbRfWdata)
	);

	// first edge is a falling one
	initial begin
		clk = 1'b1;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t ns: %s got %08h expected %08h", $time, name, got, expected);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("run stopped: %s", why);
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	endtask

	// one clock: drive at the falling edge, look mid low phase
	task automatic stepCycle();
		int lane;
		@(negedge clk);
		rst = rstReq;
		instrF = inputWords[progBase + pcF[7:2]];
		readDataM = dataMem[aluOutM[4:2]];
		if (stallsOn) begin
			// roughly one cycle in four each
			iStall = ($random(seed) & 3) == 0;
			dStall = ($random(seed) & 3) == 0;
		end else begin
			iStall = 1'b0;
			dStall = 1'b0;
		end
		#10;
		checkValue("longestStall", {31'd0, longestStall}, {31'd0, iStall | dStall});
		// store lands on the coming edge
		if (memWriteM && !longestStall) begin
			for (lane = 0; lane < 4; lane++) begin
				if (byteEnM[lane]) begin
					dataMem[aluOutM[4:2]][lane*8 +: 8] = writeDataM[lane*8 +: 8];
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one full program run
	//////////////////////////////////////////////////////////////////////

	task automatic runPass(input logic withStalls);
		int i;
		int waitCycles;
		stallsOn = 1'b0;
		for (i = 0; i < 8; i++) begin
			dataMem[i] = inputWords[dataBase + i];
		end
		rstReq = 1'b1;
		repeat (4) stepCycle();
		rstReq = 1'b0;
		stallsOn = withStalls;
		// first cycle out of reset
		stepCycle();
		checkValue("pcF", pcF, resetPc);
		checkValue("memWriteM", {31'd0, memWriteM}, 32'd0);
		checkValue("debugWbRfWen", {28'd0, debugWbRfWen}, 32'd0);
		// every write in program order
		for (i = 0; i < traceLen; i++) begin
			waitCycles = 0;
			stepCycle();
			while (debugWbRfWen == 4'd0) begin
				waitCycles++;
				if (waitCycles > wbTimeout) begin
					abortRun($sformatf("no register write for trace entry %0d", i));
				end
				stepCycle();
			end
			checkValue("debugWbPc", debugWbPc, inputWords[traceBase + 3*i]);
			checkValue("debugWbRfWnum", {27'd0, debugWbRfWnum}, inputWords[traceBase + 3*i + 1]);
			checkValue("debugWbRfWdata", debugWbRfWdata, inputWords[traceBase + 3*i + 2]);
		end
		// program now spins, nothing more may be written
		for (i = 0; i < 20; i++) begin
			stepCycle();
			checkValue("debugWbRfWen", {28'd0, debugWbRfWen}, 32'd0);
		end
		for (i = 0; i < 8; i++) begin
			checkValue($sformatf("dataMem[%0d]", i), dataMem[i], inputWords[finalBase + i]);
		end
	endtask

	initial begin
		seed = 36;
		rst = 1'b1;
		rstReq = 1'b1;
		instrF = 32'd0;
		readDataM = 32'd0;
		iStall = 1'b0;
		dStall = 1'b0;
		stallsOn = 1'b0;
		$readmemh("dv/coreInput.txt", inputWords);
		traceLen = inputWords[countIdx];
		// clean run, then the same program under random stalls
		runPass(1'b0);
		runPass(1'b1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== dv/coreInput.txt ====
// one hex word per entry; trace lines hold pc, register number, write data
// sections: @00 program, @40 initial data, @48 final data, @50 trace length, @60 trace
@00
20010005 20220003 00221820 00612022 // addi r1, addi r2, add r3, sub r4
0024282A 2006FFFD 00C1382A 00624024 // slt r5, addi r6 -3, slt r7, and r8
00664825 8C0A0004 214B0001 800C0004 // or r9, lw r10, addi r11 load-use, lb r12
01816820 800E0005 AC0D000C A0010011 // add r13 load-use, lb r14, sw r13, sb r1
10820002 200F0001 20100063 14820005 // beq taken, slot, skipped, bne not taken
20100002 2031FFFB 12200002 8C120000 // slot, addi r17, beq on r17, slot lw r18
2013004D 16400002 A0120008 20140037 // skipped, bne on r18 taken, slot sb, skipped
10220005 20150003 08000021 20160006 // beq not taken, slot, j 0x84, slot
20170042 8C180008 AC180014 23190001 // skipped, lw r24, sw r24, addi r25
08000024 00000000                   // spin on j 0x90 with nop slot
@40
11223344 80FF7F85 00000005 00000000
00000000 00000000 00000000 00000000
@48
11223344 80FF7F85 00000044 FFFFFF8A
00000500 00000044 00000000 00000000
@50
00000016
@60
00000000 00000001 00000005
00000004 00000002 00000008
00000008 00000003 0000000D
0000000C 00000004 00000008
00000010 00000005 00000001
00000014 00000006 FFFFFFFD
00000018 00000007 00000001
0000001C 00000008 00000008
00000020 00000009 FFFFFFFD
00000024 0000000A 80FF7F85
00000028 0000000B 80FF7F86
0000002C 0000000C FFFFFF85
00000030 0000000D FFFFFF8A
00000034 0000000E 0000007F
00000044 0000000F 00000001
00000050 00000010 00000002
00000054 00000011 00000000
0000005C 00000012 11223344
00000074 00000015 00000003
0000007C 00000016 00000006
00000084 00000018 00000044
0000008C 00000019 00000045

// ==== mipsCore.f ====
logic/mipsPkg.sv
logic/alu.sv
logic/regFile.sv
logic/controlDecoder.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/mipsCore.sv
dv/mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mipsCoreTb -f mipsCore.f -o simMipsCore
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/simMipsCore)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
